/* design/arch_pkg.sv */
// data and data address widths must stay equal because register values serve as addresses
package arch_pkg;

    // register and data memory word width
    localparam int data_width = 8;

    // data memory holds 2**daddr_width bytes
    localparam int daddr_width = 8;

    // program counter and fetch address width
    localparam int pc_width = 16;

    // register file size
    localparam int reg_count = 8;
    localparam int reg_addr_width = $clog2(reg_count);

    // first fetch address after reset
    localparam logic [pc_width-1:0] reset_pc = '0;

endpackage

/* design/isa_pkg.sv */
// 16-bit instruction encoding that needs arch_pkg compiled first; opcodes E and F are reserved
package isa_pkg;

    localparam int instr_width = 16;
    localparam int opcode_width = 4;
    localparam int imm_width = 8;
    localparam int spare_width = imm_width - 2 * arch_pkg::reg_addr_width;

    typedef enum logic [opcode_width-1:0] {
        op_mov   = 4'h0,
        op_add   = 4'h1,
        op_sub   = 4'h2,
        op_jmp   = 4'h3,
        op_load  = 4'h4,
        op_store = 4'h5,
        op_adc   = 4'h6,
        op_sbc   = 4'h7,
        op_cmp   = 4'h8,
        op_jz    = 4'h9,
        op_jc    = 4'ha,
        op_jn    = 4'hb,
        op_jge   = 4'hc,
        op_jgt   = 4'hd,
        op_push  = 4'he,
        op_pop   = 4'hf
    } opcode_e;

    // bit 11 selects the immediate form, or inverts a branch condition
    typedef union packed {
        struct packed {
            opcode_e                             opcode;
            logic                                flag;
            logic [arch_pkg::reg_addr_width-1:0] ra;
            logic [arch_pkg::reg_addr_width-1:0] rb;
            logic [arch_pkg::reg_addr_width-1:0] rc;
            logic [spare_width-1:0]              spare;
        } reg_form;
        struct packed {
            opcode_e                             opcode;
            logic                                flag;
            logic [arch_pkg::reg_addr_width-1:0] ra;
            logic [imm_width-1:0]                imm8;
        } imm_form;
    } instr_t;

    typedef enum logic [2:0] {
        cond_always,
        cond_zero,
        cond_carry,
        cond_negative,
        cond_ge,
        cond_gt,
        cond_never
    } cond_e;

    typedef enum logic [1:0] {
        carry_zero,
        carry_one,
        carry_flag
    } carry_sel_e;

endpackage

/* design/decode_if.sv */
// decoded control bundle that only the decoder drives, all controls are combinational
`timescale 1ns/1ps

interface decode_if;

    import arch_pkg::*;
    import isa_pkg::*;

    logic [reg_addr_width-1:0] ra;
    logic [reg_addr_width-1:0] rb;
    logic [reg_addr_width-1:0] rc;
    logic [imm_width-1:0]      imm8;
    logic                      imm_sel;
    logic                      reg_we;
    logic                      wb_from_mem;
    logic                      use_adder;
    logic                      invert_b;
    carry_sel_e                carry_sel;
    logic                      flags_we;
    logic                      mem_we;
    logic                      addr_from_reg;
    cond_e                     cond;
    logic                      cond_invert;

    modport decoder (
        output ra, rb, rc, imm8, imm_sel, reg_we, wb_from_mem, use_adder, invert_b,
        output carry_sel, flags_we, mem_we, addr_from_reg, cond, cond_invert
    );

    modport datapath (
        input ra, rb, rc, imm8, imm_sel, reg_we, wb_from_mem, use_adder, invert_b,
        input carry_sel, flags_we, mem_we, addr_from_reg
    );

    modport pc (
        input cond, cond_invert, imm8
    );

endinterface

/* design/instr_decode.sv */
// combinational decoder; push and pop (E, F) decode to no-ops that only advance the pc
`timescale 1ns/1ps

module instr_decode (
    input isa_pkg::instr_t instr,
    decode_if.decoder      dec
);

    import isa_pkg::*;

    always_comb begin
        // register fields come from the reg view, the constant from the imm view
        dec.ra = instr.imm_form.ra;
        dec.rb = instr.reg_form.rb;
        dec.rc = instr.reg_form.rc;
        dec.imm8 = instr.imm_form.imm8;
        dec.imm_sel = 1'b0;
        dec.reg_we = 1'b0;
        dec.wb_from_mem = 1'b0;
        dec.use_adder = 1'b0;
        dec.invert_b = 1'b0;
        dec.carry_sel = carry_zero;
        dec.flags_we = 1'b0;
        dec.mem_we = 1'b0;
        dec.addr_from_reg = 1'b0;
        dec.cond = cond_never;
        dec.cond_invert = 1'b0;

        case (instr.imm_form.opcode)
            op_mov: begin
                dec.reg_we = 1'b1;
                dec.imm_sel = instr.imm_form.flag;
                // route rb onto read port b so the alu pass-through sees it
                dec.rc = instr.reg_form.rb;
            end
            op_add, op_sub, op_adc, op_sbc, op_cmp: begin
                dec.imm_sel = instr.imm_form.flag;
                dec.use_adder = 1'b1;
                dec.flags_we = 1'b1;
                dec.reg_we = (instr.imm_form.opcode != op_cmp);
                dec.invert_b = (instr.imm_form.opcode inside {op_sub, op_sbc, op_cmp});
                if (instr.imm_form.opcode inside {op_adc, op_sbc}) begin
                    dec.carry_sel = carry_flag;
                end else if (dec.invert_b) begin
                    dec.carry_sel = carry_one;
                end
            end
            op_load: begin
                dec.reg_we = 1'b1;
                dec.wb_from_mem = 1'b1;
                dec.addr_from_reg = ~instr.imm_form.flag;
            end
            op_store: begin
                dec.mem_we = 1'b1;
                dec.addr_from_reg = ~instr.reg_form.flag;
            end
            op_jmp: begin
                dec.cond = cond_always;
            end
            op_jz, op_jc, op_jn, op_jge, op_jgt: begin
                dec.cond_invert = instr.imm_form.flag;
                unique case (instr.imm_form.opcode)
                    op_jz:   dec.cond = cond_zero;
                    op_jc:   dec.cond = cond_carry;
                    op_jn:   dec.cond = cond_negative;
                    op_jge:  dec.cond = cond_ge;
                    default: dec.cond = cond_gt;
                endcase
            end
            default: begin
                // push and pop are not implemented and fall through as no-ops
                dec.cond = cond_never;
            end
        endcase
    end

endmodule

/* design/reg_file.sv */
// eight 8-bit registers without reset, so software must write a register before reading it
`timescale 1ns/1ps

module reg_file (
    input  logic       clk,
    input  logic       we,
    input  logic [2:0] waddr,
    input  logic [7:0] wdata,
    input  logic [2:0] raddr_a,
    input  logic [2:0] raddr_b,
    output logic [7:0] rdata_a,
    output logic [7:0] rdata_b
);

    logic [7:0] regs [0:7];

    // single write port, lands at the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // reads see the old value during a write to the same register
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

/* design/alu.sv */
// 8-bit add/subtract with registered flags; the result is combinational and flags lag one cycle
`timescale 1ns/1ps

module alu (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [arch_pkg::data_width-1:0] a,
    input  logic [arch_pkg::data_width-1:0] b,
    decode_if.datapath                     dec,
    output logic [arch_pkg::data_width-1:0] result,
    output logic                           flag_c,
    output logic                           flag_v,
    output logic                           flag_n,
    output logic                           flag_z
);

    import arch_pkg::*;
    import isa_pkg::*;

    logic [data_width-1:0] b_eff;
    logic                  carry_in;
    logic [data_width-1:0] low_sum;
    logic [1:0]            top_sum;
    logic [data_width-1:0] sum;
    logic                  carry_msb;
    logic                  carry_out;

    always_comb begin
        b_eff = dec.invert_b ? ~b : b;

        case (dec.carry_sel)
            carry_one:  carry_in = 1'b1;
            carry_flag: carry_in = flag_c;
            default:    carry_in = 1'b0;
        endcase

        // split at the msb so the carry into bit 7 is visible for overflow
        low_sum = {1'b0, a[data_width-2:0]} + {1'b0, b_eff[data_width-2:0]}
                  + data_width'(carry_in);
        carry_msb = low_sum[data_width-1];
        top_sum = 2'(a[data_width-1]) + 2'(b_eff[data_width-1]) + 2'(carry_msb);
        carry_out = top_sum[1];
        sum = {top_sum[0], low_sum[data_width-2:0]};
    end

    // mov and load take operand b unchanged
    assign result = dec.use_adder ? sum : b;

    always_ff @(posedge clk) begin
        if (reset) begin
            flag_c <= 1'b0;
            flag_v <= 1'b0;
            flag_n <= 1'b0;
            flag_z <= 1'b0;
        end else if (dec.flags_we) begin
            // c=1 on subtraction means no borrow
            flag_c <= carry_out;
            flag_v <= carry_msb ^ carry_out;
            flag_n <= result[data_width-1];
            flag_z <= (result == '0);
        end
    end

endmodule

/* design/datapath.sv */
// operand, memory and write-back muxing around the register file; memories answer same cycle
`timescale 1ns/1ps

module datapath (
    input  logic                             clk,
    input  logic                             reset,
    decode_if.datapath                       dec,
    input  logic [arch_pkg::data_width-1:0]  data_rdata,
    output logic [arch_pkg::daddr_width-1:0] data_addr,
    output logic [arch_pkg::data_width-1:0]  data_wdata,
    output logic                             data_we,
    output logic                             flag_c,
    output logic                             flag_v,
    output logic                             flag_n,
    output logic                             flag_z
);

    import arch_pkg::*;

    logic [reg_addr_width-1:0] raddr_a;
    logic [data_width-1:0]     rdata_a;
    logic [data_width-1:0]     rdata_b;
    logic [data_width-1:0]     operand_b;
    logic [data_width-1:0]     alu_result;
    logic [data_width-1:0]     wb_data;
    logic                      read_ra;

    // ra goes on port a for immediate forms, stores and cmp (flags without write-back)
    assign read_ra = dec.imm_sel | dec.mem_we | (dec.flags_we & ~dec.reg_we);
    assign raddr_a = read_ra ? dec.ra : dec.rb;

    assign operand_b = dec.imm_sel ? dec.imm8 : rdata_b;

    assign data_addr = dec.addr_from_reg ? rdata_b : dec.imm8;
    assign data_wdata = rdata_a;
    assign data_we = dec.mem_we & ~reset;

    assign wb_data = dec.wb_from_mem ? data_rdata : alu_result;

    reg_file u_reg_file (
        .clk     (clk),
        .we      (dec.reg_we),
        .waddr   (dec.ra),
        .wdata   (wb_data),
        .raddr_a (raddr_a),
        .raddr_b (dec.rc),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    alu u_alu (
        .clk    (clk),
        .reset  (reset),
        .a      (rdata_a),
        .b      (operand_b),
        .dec    (dec),
        .result (alu_result),
        .flag_c (flag_c),
        .flag_v (flag_v),
        .flag_n (flag_n),
        .flag_z (flag_z)
    );

endmodule

/* design/pc_unit.sv */
// 16-bit pc with relative branches of -128 to +127 words; the pc wraps at the top of memory
`timescale 1ns/1ps

module pc_unit (
    input  logic                          clk,
    input  logic                          reset,
    decode_if.pc                          dec,
    input  logic                          flag_c,
    input  logic                          flag_v,
    input  logic                          flag_n,
    input  logic                          flag_z,
    output logic [arch_pkg::pc_width-1:0] pc
);

    import arch_pkg::*;
    import isa_pkg::*;

    logic                cond_hold;
    logic                taken;
    logic [pc_width-1:0] offset;
    logic [pc_width-1:0] pc_next;

    always_comb begin
        case (dec.cond)
            cond_always:   cond_hold = 1'b1;
            cond_zero:     cond_hold = flag_z;
            cond_carry:    cond_hold = flag_c;
            cond_negative: cond_hold = flag_n;
            // signed compare from the last subtraction
            cond_ge:       cond_hold = (flag_n == flag_v);
            cond_gt:       cond_hold = (flag_n == flag_v) & ~flag_z;
            default:       cond_hold = 1'b0;
        endcase
    end

    assign taken = cond_hold ^ dec.cond_invert;

    // sign extend the branch offset to the pc width
    assign offset = {{(pc_width-imm_width){dec.imm8[imm_width-1]}}, dec.imm8};

    assign pc_next = pc + (taken ? offset : pc_width'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* design/cpu_core.sv */
// single-cycle core; instr and data_rdata must be returned combinationally in the same cycle
`timescale 1ns/1ps

module cpu_core (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [isa_pkg::instr_width-1:0]  instr,
    input  logic [arch_pkg::data_width-1:0]  data_rdata,
    output logic [arch_pkg::pc_width-1:0]    pc,
    output logic [arch_pkg::daddr_width-1:0] data_addr,
    output logic [arch_pkg::data_width-1:0]  data_wdata,
    output logic                             data_we
);

    import isa_pkg::*;

    instr_t instr_word;
    logic   flag_c;
    logic   flag_v;
    logic   flag_n;
    logic   flag_z;

    assign instr_word = instr;

    decode_if dec_bus ();

    instr_decode u_instr_decode (
        .instr (instr_word),
        .dec   (dec_bus.decoder)
    );

    datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec_bus.datapath),
        .data_rdata (data_rdata),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .flag_c     (flag_c),
        .flag_v     (flag_v),
        .flag_n     (flag_n),
        .flag_z     (flag_z)
    );

    pc_unit u_pc_unit (
        .clk    (clk),
        .reset  (reset),
        .dec    (dec_bus.pc),
        .flag_c (flag_c),
        .flag_v (flag_v),
        .flag_n (flag_n),
        .flag_z (flag_z),
        .pc     (pc)
    );

endmodule

/* sim/cpu_core_assert.sv */
// port-level checks on cpu_core, bound into every instance of the core
`timescale 1ns/1ps

module cpu_core_assert (
    input logic                             clk,
    input logic                             reset,
    input logic [arch_pkg::pc_width-1:0]    pc,
    input logic [arch_pkg::daddr_width-1:0] data_addr,
    input logic [arch_pkg::data_width-1:0]  data_wdata,
    input logic                             data_we
);

    import arch_pkg::*;

    // no store may leave the core while it is held in reset
    assert property (@(posedge clk) reset |-> !data_we)
        else $error("data_we high during reset");

    // a store must carry a known address and data
    assert property (@(posedge clk) disable iff (reset)
        data_we |-> !$isunknown({data_addr, data_wdata}))
        else $error("unknown store address or data");

    // first cycle out of reset fetches from the reset vector
    assert property (@(posedge clk) $fell(reset) |-> (pc == reset_pc))
        else $error("pc not at reset vector after reset");

endmodule

bind cpu_core cpu_core_assert u_cpu_core_assert (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we)
);

/* sim/tb_cpu_core.sv */
// memories answer combinationally; program space is 256 words and data space 256 bytes
`timescale 1ns/1ps

module tb_cpu_core;

    import isa_pkg::*;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
    } store_t;

    localparam int wait_limit = 200;

    logic        clk;
    logic        reset;
    logic [15:0] instr;
    logic [7:0]  data_rdata;
    logic [15:0] pc;
    logic [7:0]  data_addr;
    logic [7:0]  data_wdata;
    logic        data_we;

    logic [15:0] imem [0:255];
    logic [7:0]  dmem [0:255];
    logic [7:0]  preload [0:255];
    logic [15:0] program_q [$];
    store_t      expected [$];
    integer      seed;
    int          good_addr;
    int          poison_addr;
    int          halt_pc;

    cpu_core u_cpu_core (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .data_rdata (data_rdata),
        .pc         (pc),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction and data memories
    assign instr = imem[pc[7:0]];
    assign data_rdata = dmem[data_addr];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr] <= data_wdata;
        end
    end

    function automatic logic [15:0] imm_word(opcode_e op, logic flag, logic [2:0] ra,
                                             logic [7:0] imm);
        return {op, flag, ra, imm};
    endfunction

    function automatic logic [15:0] reg_word(opcode_e op, logic [2:0] ra, logic [2:0] rb,
                                             logic [2:0] rc);
        return {op, 1'b0, ra, rb, rc, 2'b00};
    endfunction

    task automatic emit(logic [15:0] word);
        program_q.push_back(word);
    endtask

    // store with an immediate address, and the store the testbench should see
    task automatic store_to(logic [2:0] ra, logic [7:0] addr, logic [7:0] value);
        emit(imm_word(op_store, 1'b1, ra, addr));
        expected.push_back('{addr: addr, data: value});
    endtask

    task automatic store_via_reg(logic [2:0] ra, logic [2:0] rc, logic [7:0] addr,
                                 logic [7:0] value);
        emit(reg_word(op_store, ra, 3'd0, rc));
        expected.push_back('{addr: addr, data: value});
    endtask

    // a taken jump of +2 skips the poison store
    task automatic taken_branch(opcode_e op, logic inv);
        emit(imm_word(op, inv, 3'd0, 8'h02));
        emit(imm_word(op_store, 1'b1, 3'd7, 8'(poison_addr)));
        poison_addr++;
        store_to(3'd6, 8'(good_addr), 8'ha5);
        good_addr++;
    endtask

    // a wrongly taken jump would skip the marker store
    task automatic untaken_branch(opcode_e op, logic inv);
        emit(imm_word(op, inv, 3'd0, 8'h02));
        store_to(3'd6, 8'(good_addr), 8'ha5);
        good_addr++;
    endtask

    task automatic build_program();
        good_addr = 8'h90;
        poison_addr = 8'hc0;
        // mov, add and sub in both forms
        emit(imm_word(op_mov, 1'b1, 3'd1, 8'h12));
        store_to(3'd1, 8'h80, 8'h12);
        emit(reg_word(op_mov, 3'd2, 3'd1, 3'd0));
        store_to(3'd2, 8'h81, 8'h12);
        emit(imm_word(op_add, 1'b1, 3'd2, 8'h05));
        store_to(3'd2, 8'h82, 8'h17);
        emit(imm_word(op_mov, 1'b1, 3'd3, 8'h30));
        emit(reg_word(op_add, 3'd4, 3'd3, 3'd2));
        store_to(3'd4, 8'h83, 8'h47);
        emit(imm_word(op_sub, 1'b1, 3'd4, 8'h07));
        store_to(3'd4, 8'h84, 8'h40);
        emit(reg_word(op_sub, 3'd5, 3'd3, 3'd2));
        store_to(3'd5, 8'h85, 8'h19);
        // 0xf0 + 0x20 carries out, adc then adds the carry in
        emit(imm_word(op_mov, 1'b1, 3'd1, 8'hf0));
        emit(imm_word(op_add, 1'b1, 3'd1, 8'h20));
        emit(imm_word(op_mov, 1'b1, 3'd2, 8'h01));
        emit(imm_word(op_adc, 1'b1, 3'd2, 8'h01));
        store_to(3'd2, 8'h86, 8'h03);
        store_to(3'd1, 8'h87, 8'h10);
        // c is clear here so the first sbc borrows one extra
        emit(imm_word(op_sbc, 1'b1, 3'd3, 8'h10));
        store_to(3'd3, 8'h88, 8'h1f);
        emit(imm_word(op_sbc, 1'b1, 3'd3, 8'h0f));
        store_to(3'd3, 8'h89, 8'h10);
        // loads of random bytes, stored back in both address forms
        emit(imm_word(op_load, 1'b1, 3'd4, 8'h10));
        store_to(3'd4, 8'h8b, preload[8'h10]);
        emit(imm_word(op_mov, 1'b1, 3'd5, 8'h11));
        emit(reg_word(op_load, 3'd4, 3'd0, 3'd5));
        emit(imm_word(op_mov, 1'b1, 3'd5, 8'h8c));
        store_via_reg(3'd4, 3'd5, 8'h8c, preload[8'h11]);
        // marker and poison values, then z=1 c=1 n=0 v=0
        emit(imm_word(op_mov, 1'b1, 3'd6, 8'ha5));
        emit(imm_word(op_mov, 1'b1, 3'd7, 8'hee));
        emit(imm_word(op_cmp, 1'b1, 3'd3, 8'h10));
        store_to(3'd3, 8'h8a, 8'h10);
        taken_branch(op_jz, 1'b0);
        untaken_branch(op_jz, 1'b1);
        taken_branch(op_jc, 1'b0);
        untaken_branch(op_jc, 1'b1);
        untaken_branch(op_jn, 1'b0);
        taken_branch(op_jn, 1'b1);
        taken_branch(op_jge, 1'b0);
        untaken_branch(op_jge, 1'b1);
        untaken_branch(op_jgt, 1'b0);
        taken_branch(op_jgt, 1'b1);
        // 0x10 - 0x20 gives z=0 c=0 n=1 v=0
        emit(imm_word(op_cmp, 1'b1, 3'd3, 8'h20));
        untaken_branch(op_jz, 1'b0);
        taken_branch(op_jz, 1'b1);
        untaken_branch(op_jc, 1'b0);
        taken_branch(op_jc, 1'b1);
        taken_branch(op_jn, 1'b0);
        untaken_branch(op_jn, 1'b1);
        untaken_branch(op_jge, 1'b0);
        taken_branch(op_jge, 1'b1);
        untaken_branch(op_jgt, 1'b0);
        // register form, 0x10 - r2 (0x03) gives z=0 c=1 n=0 v=0
        emit(reg_word(op_cmp, 3'd3, 3'd0, 3'd2));
        taken_branch(op_jgt, 1'b0);
        untaken_branch(op_jgt, 1'b1);
        taken_branch(op_jn, 1'b1);
        untaken_branch(op_jz, 1'b0);
        // 0x80 - 0x01 overflows and gives z=0 c=1 n=0 v=1
        emit(imm_word(op_mov, 1'b1, 3'd5, 8'h80));
        emit(imm_word(op_cmp, 1'b1, 3'd5, 8'h01));
        untaken_branch(op_jge, 1'b0);
        taken_branch(op_jge, 1'b1);
        untaken_branch(op_jgt, 1'b0);
        taken_branch(op_jmp, 1'b0);
        // push and pop slots do nothing
        emit(imm_word(op_push, 1'b1, 3'd6, 8'h00));
        emit(imm_word(op_pop, 1'b0, 3'd6, 8'h55));
        store_to(3'd6, 8'hb0, 8'ha5);
        halt_pc = program_q.size();
        emit(imm_word(op_jmp, 1'b0, 3'd0, 8'h00));
    endtask

    task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_abort(string what);
        $display("timed out while waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    endtask

    task automatic wait_for_store();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (data_we !== 1'b1) begin
            if (cycles >= wait_limit) begin
                timeout_abort("the next store");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        int stable;
        logic [15:0] last;
        cycles = 0;
        stable = 0;
        last = pc;
        while (stable < 4) begin
            @(negedge clk);
            cycles++;
            if (pc === last) begin
                stable++;
            end else begin
                stable = 0;
                last = pc;
            end
            if (cycles >= wait_limit) begin
                timeout_abort("the pc to stop");
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        seed = 8656;
        for (int i = 0; i < 256; i++) begin
            // low bytes are random, the rest a pattern of the address
            preload[i] = (i < 64) ? 8'($random(seed)) : (8'(i) ^ 8'h3c);
            dmem[i] = preload[i];
            imem[i] = imm_word(op_jmp, 1'b0, 3'd0, 8'h00);
        end
        build_program();
        foreach (program_q[i]) begin
            imem[i] = program_q[i];
        end
        // a store parked at the reset vector must not leak out while reset is high
        imem[0] = imm_word(op_store, 1'b1, 3'd0, 8'hff);

        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_value("data_we", 16'(data_we), 16'h0);
        end
        @(posedge clk);
        reset <= 1'b0;
        imem[0] <= program_q[0];
        @(negedge clk);
        check_value("pc", pc, 16'h0000);

        foreach (expected[k]) begin
            wait_for_store();
            check_value("data_addr", 16'(data_addr), 16'(expected[k].addr));
            check_value("data_wdata", 16'(data_wdata), 16'(expected[k].data));
        end

        wait_for_halt();
        check_value("pc", pc, 16'(halt_pc));
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* src.f */
design/arch_pkg.sv
design/isa_pkg.sv
design/decode_if.sv
design/instr_decode.sv
design/reg_file.sv
design/alu.sv
design/datapath.sv
design/pc_unit.sv
design/cpu_core.sv
sim/cpu_core_assert.sv
sim/tb_cpu_core.sv

/* Makefile */
# Verilator build for the cpu_core testbench
# override any variable from the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_cpu_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -sv

FAIL_MSG := *** TEST FAILED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
